/* source/mem_macros.svh */
//**********************************************************
// memory stage constants
// cache message codes, size codes and response timeout
//**********************************************************
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// request types toward the cache
`define MEM_LOAD_RQ         4'b0000
`define MEM_STORE_RQ        4'b0001

// return types from the cache
`define MEM_LOAD_RET        4'b0000
`define MEM_ST_ACK          4'b0100

// message data size
`define MEM_SIZE_0B         3'b000
`define MEM_SIZE_1B         3'b001
`define MEM_SIZE_2B         3'b010
`define MEM_SIZE_4B         3'b011

// cycles a transaction may wait on the cache before abort
`define MEM_TIMEOUT_CYCLES  64

`endif

/* source/mem_op_pkg.sv */
//**********************************************************
// core-side memory types
// operation code, issue bundle and decoded access
//**********************************************************
`default_nettype none

package mem_op_pkg;

    // access width, op bits 2:1
    typedef enum logic [1:0] {
        SZ_HALF = 2'b01,
        SZ_BYTE = 2'b10,
        SZ_WORD = 2'b11
    } mem_size_t;

    // 1111 sw, 1011 sh, 1101 sb
    // 0111 lw, 0011 lh, 0010 lhu, 0101 lb, 0100 lbu
    // 0000 means no memory operation
    typedef struct packed {
        logic      store;   // 1 store, 0 load
        mem_size_t size;
        logic      sgn;     // sign extend on load
    } mem_op_t;

    typedef struct packed {
        mem_op_t     op;
        logic [31:0] base;
        logic [31:0] operand;  // load offset or store data
        logic [31:0] st_off;   // store offset
    } mem_in_t;

    typedef struct packed {
        logic        valid;
        mem_op_t     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [3:0]  be;       // byte 0 at bit 0
        logic        rd;       // aligned load
        logic        ld_mis;
        logic        st_mis;
    } mem_acc_t;

endpackage

`default_nettype wire

/* source/l15_pkg.sv */
//**********************************************************
// cache-side types
// request, response and message size
//**********************************************************
`default_nettype none

package l15_pkg;

    // request and return type code
    typedef logic [3:0] l15_type_t;

    // message data size code
    typedef logic [2:0] l15_size_t;

    typedef struct packed {
        l15_type_t   rqtype;
        l15_size_t   size;
        logic [31:0] addr;
        logic [31:0] data;     // big endian byte order
    } l15_req_t;

    // a response carries a 16-byte line
    // data_0 high half holds the word at offset 0
    typedef struct packed {
        logic [63:0] data_0;
        logic [63:0] data_1;
        l15_type_t   rettype;
    } l15_resp_t;

endpackage

`default_nettype wire

/* source/mem_decode.sv */
//**********************************************************
// memory access decode, two pipeline stages
// address add, byte enables and misalignment detection
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module mem_decode (
    input  logic                 clk,
    input  logic                 nrst,
    input  mem_op_pkg::mem_in_t  issue,
    output mem_op_pkg::mem_acc_t acc
);
    import mem_op_pkg::*;

    mem_in_t     s5;
    mem_acc_t    d5;
    logic        valid5;
    logic [31:0] addr5;
    logic        mis5;
    logic [3:0]  be5;

    // stage 5 register
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            s5 <= '0;
        end else begin
            s5 <= issue;
        end
    end

    assign valid5 = (s5.op != '0);

    // loads use base + operand, stores base + store offset
    assign addr5 = s5.op.store ? (s5.base + s5.st_off) : (s5.base + s5.operand);

    assign mis5 = ((s5.op.size == SZ_HALF) && addr5[0]) ||
                  ((s5.op.size == SZ_WORD) && (addr5[1:0] != 2'b00));

    // byte enables, stores only
    always_comb begin
        be5 = 4'b0000;
        if (valid5 && s5.op.store && !mis5) begin
            case (s5.op.size)
                SZ_WORD: be5 = 4'b1111;
                SZ_HALF: be5 = addr5[1] ? 4'b1100 : 4'b0011;
                SZ_BYTE: be5 = 4'b0001 << addr5[1:0];
                default: be5 = 4'b0000;
            endcase
        end
    end

    always_comb begin
        d5.valid  = valid5;
        d5.op     = s5.op;
        d5.addr   = addr5;
        d5.wdata  = s5.operand;
        d5.be     = be5;
        d5.rd     = valid5 && !s5.op.store && !mis5;
        d5.ld_mis = valid5 && !s5.op.store && mis5;
        d5.st_mis = valid5 && s5.op.store && mis5;
    end

    // stage 6 register
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            acc <= '0;
        end else begin
            acc <= d5;
        end
    end

endmodule

`default_nettype wire

/* source/l15_req_fsm.sv */
//**********************************************************
// cache request FSM
// one request at a time, return type match, done and error
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

`include "mem_macros.svh"

module l15_req_fsm (
    input  logic                 clk,
    input  logic                 nrst,
    input  mem_op_pkg::mem_acc_t acc,
    input  logic [31:0]          store_word,
    output l15_pkg::l15_req_t    req,
    output logic                 req_val,
    input  logic                 header_ack,
    input  logic [3:0]           resp_type,
    input  logic                 resp_val,
    output logic                 req_ack,
    input  logic                 timeout,
    output logic                 busy,
    output logic                 resp_take,
    output logic                 mem_done,
    output logic                 mem_err
);
    import l15_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT, S_DONE} state_t;

    state_t      state;
    logic        rd_q;
    logic [31:0] addr_q;
    logic [31:0] data_q;
    logic [3:0]  be_q;
    l15_type_t   ret_exp;
    l15_size_t   size_c;
    logic        match;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            state   <= S_IDLE;
            rd_q    <= 1'b0;
            mem_err <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (acc.valid) begin
                        rd_q    <= acc.rd;
                        mem_err <= 1'b0;
                        // misaligned access never reaches the cache
                        state   <= (acc.ld_mis || acc.st_mis) ? S_DONE : S_REQ;
                    end
                end
                S_REQ: begin
                    if (timeout) begin
                        state   <= S_DONE;
                        mem_err <= 1'b1;
                    end else if (header_ack) begin
                        state <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (match) begin
                        state <= S_DONE;
                    end else if (timeout) begin
                        state   <= S_DONE;
                        mem_err <= 1'b1;
                    end
                end
                default: state <= S_IDLE;   // S_DONE lasts one cycle
            endcase
        end
    end

    // request payload, held for the whole transaction
    always_ff @(posedge clk) begin
        if (state == S_IDLE && acc.valid) begin
            addr_q <= acc.addr;
            data_q <= store_word;
            be_q   <= acc.be;
        end
    end

    assign busy     = (state == S_REQ) || (state == S_WAIT);
    assign req_val  = (state == S_REQ);
    assign mem_done = (state == S_DONE);

    assign ret_exp   = rd_q ? `MEM_LOAD_RET : `MEM_ST_ACK;
    assign match     = (state == S_WAIT) && resp_val && (resp_type == ret_exp);
    assign req_ack   = match;
    assign resp_take = match;

    // loads always fetch a full word
    always_comb begin
        if (rd_q) begin
            size_c = `MEM_SIZE_4B;
        end else begin
            case (be_q)
                4'b1111:                            size_c = `MEM_SIZE_4B;
                4'b0011, 4'b1100:                   size_c = `MEM_SIZE_2B;
                4'b0001, 4'b0010, 4'b0100, 4'b1000: size_c = `MEM_SIZE_1B;
                default:                            size_c = `MEM_SIZE_0B;
            endcase
        end
    end

    assign req = '{
        rqtype: (rd_q ? `MEM_LOAD_RQ : `MEM_STORE_RQ),
        size:   size_c,
        addr:   addr_q,
        data:   data_q
    };

endmodule

`default_nettype wire

/* source/resp_timer.sv */
//**********************************************************
// cache response timer
// counts busy cycles, flags a timeout at the limit
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

`include "mem_macros.svh"

module resp_timer (
    input  logic clk,
    input  logic nrst,
    input  logic busy,
    output logic timeout
);
    localparam int CNT_W = $clog2(`MEM_TIMEOUT_CYCLES + 1);
    localparam logic [CNT_W-1:0] LIMIT = CNT_W'(`MEM_TIMEOUT_CYCLES);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            cnt <= '0;
        end else if (!busy) begin
            cnt <= '0;                  // idle clears the count
        end else if (cnt != LIMIT) begin
            cnt <= cnt + 1'b1;          // saturates at the limit
        end
    end

    assign timeout = (cnt == LIMIT);

endmodule

`default_nettype wire

/* source/l15_data_align.sv */
//**********************************************************
// cache data alignment
// store byte swap, load word select, swap and extension
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module l15_data_align (
    input  logic                clk,
    input  logic                nrst,
    input  mem_op_pkg::mem_op_t op,
    input  logic [31:0]         addr,
    input  logic [31:0]         store_data,
    input  l15_pkg::l15_resp_t  resp,
    input  logic                take,
    output logic [31:0]         store_word,
    output logic [31:0]         load_data
);
    import mem_op_pkg::*;

    mem_op_t         op_q;
    logic [3:0]      addr_q;
    logic [31:0]     word_be;
    logic [3:0][7:0] word_le;
    logic [7:0]      byte_sel;
    logic [15:0]     half_sel;
    logic [31:0]     ext;

    // cache is big endian
    assign store_word = {store_data[7:0], store_data[15:8],
                         store_data[23:16], store_data[31:24]};

    // keep the attributes of the last valid access until the response
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            op_q <= '0;
        end else if (op != '0) begin
            op_q <= op;
        end
    end

    always_ff @(posedge clk) begin
        if (op != '0) begin
            addr_q <= addr[3:0];     // line offset only
        end
    end

    always_comb begin
        case (addr_q[3:2])
            2'b00:   word_be = resp.data_0[63:32];
            2'b01:   word_be = resp.data_0[31:0];
            2'b10:   word_be = resp.data_1[63:32];
            default: word_be = resp.data_1[31:0];
        endcase
    end

    assign word_le  = {word_be[7:0], word_be[15:8], word_be[23:16], word_be[31:24]};
    assign byte_sel = word_le[addr_q[1:0]];
    assign half_sel = addr_q[1] ? word_le[3:2] : word_le[1:0];

    always_comb begin
        case (op_q.size)
            SZ_BYTE: ext = op_q.sgn ? {{24{byte_sel[7]}}, byte_sel} : {24'b0, byte_sel};
            SZ_HALF: ext = op_q.sgn ? {{16{half_sel[15]}}, half_sel} : {16'b0, half_sel};
            default: ext = word_le;
        endcase
    end

    // loads only, stores leave the last value
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            load_data <= '0;
        end else if (take && !op_q.store) begin
            load_data <= ext;
        end
    end

endmodule

`default_nettype wire

/* source/mem_wrap.sv */
//**********************************************************
// memory stage top
// decode, request FSM, timer and aligner on core and cache ports
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module mem_wrap (
    input  logic                clk,
    input  logic                nrst,
    input  mem_op_pkg::mem_in_t issue,
    output l15_pkg::l15_req_t   req,
    output logic                req_val,
    input  logic                header_ack,
    input  l15_pkg::l15_resp_t  resp,
    input  logic                resp_val,
    output logic                req_ack,
    output logic [31:0]         load_data,
    output logic                mem_done,
    output logic                mem_err,
    output logic                ld_misaligned,
    output logic                st_misaligned
);
    import mem_op_pkg::*;

    mem_acc_t    acc;
    logic [31:0] store_word;
    logic        busy;
    logic        timeout;
    logic        resp_take;

    mem_decode u_decode (
        .clk   (clk),
        .nrst  (nrst),
        .issue (issue),
        .acc   (acc)
    );

    l15_req_fsm u_fsm (
        .clk        (clk),
        .nrst       (nrst),
        .acc        (acc),
        .store_word (store_word),
        .req        (req),
        .req_val    (req_val),
        .header_ack (header_ack),
        .resp_type  (resp.rettype),
        .resp_val   (resp_val),
        .req_ack    (req_ack),
        .timeout    (timeout),
        .busy       (busy),
        .resp_take  (resp_take),
        .mem_done   (mem_done),
        .mem_err    (mem_err)
    );

    resp_timer u_timer (
        .clk     (clk),
        .nrst    (nrst),
        .busy    (busy),
        .timeout (timeout)
    );

    l15_data_align u_align (
        .clk        (clk),
        .nrst       (nrst),
        .op         (acc.op),
        .addr       (acc.addr),
        .store_data (acc.wdata),
        .resp       (resp),
        .take       (resp_take),
        .store_word (store_word),
        .load_data  (load_data)
    );

    // flags come straight from the stage 6 access
    assign ld_misaligned = acc.ld_mis;
    assign st_misaligned = acc.st_mis;

endmodule

`default_nettype wire

/* testbench/mem_wrap_tb.sv */
//**********************************************************
// memory stage testbench
// cache model, vector reader and result checks
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

`include "mem_macros.svh"

module mem_wrap_tb;
    import mem_op_pkg::*;
    import l15_pkg::*;

    logic        clk = 1'b0;
    logic        nrst;
    mem_in_t     issue;
    l15_req_t    req;
    logic        req_val;
    logic        header_ack;
    l15_resp_t   resp;
    logic        resp_val;
    logic        req_ack;
    logic [31:0] load_data;
    logic        mem_done;
    logic        mem_err;
    logic        ld_misaligned;
    logic        st_misaligned;

    // columns of one vector line
    // op base operand st_off data_0 data_1
    // exp_type exp_size exp_addr exp_data exp_load ld_mis st_mis hold
    logic [3:0]  v_op;
    logic [31:0] v_base, v_operand, v_st_off;
    logic [63:0] v_d0, v_d1;
    logic [3:0]  v_type;
    logic [2:0]  v_size;
    logic [31:0] v_addr, v_data, v_load;
    logic        v_ldmis, v_stmis, v_hold;

    integer      seed;
    integer      fd;
    int          vec_idx;

    mem_wrap dut0 (
        .clk           (clk),
        .nrst          (nrst),
        .issue         (issue),
        .req           (req),
        .req_val       (req_val),
        .header_ack    (header_ack),
        .resp          (resp),
        .resp_val      (resp_val),
        .req_ack       (req_ack),
        .load_data     (load_data),
        .mem_done      (mem_done),
        .mem_err       (mem_err),
        .ld_misaligned (ld_misaligned),
        .st_misaligned (st_misaligned)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    function automatic string vec_label(input string what);
        return $sformatf("vector %0d %s", vec_idx, what);
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("Verification failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out waiting for %s in vector %0d", what, vec_idx);
        $display("Verification failed");
        $fatal(1, "wait limit reached");
    endtask

    // request header against the vector
    task automatic expect_request(input string when);
        check_value(vec_label({"req_val", when}), 32'd1, 32'(req_val));
        check_value(vec_label({"req type", when}), 32'(v_type), 32'(req.rqtype));
        check_value(vec_label({"req size", when}), 32'(v_size), 32'(req.size));
        check_value(vec_label({"req addr", when}), v_addr, req.addr);
        if (v_op[3]) begin
            check_value(vec_label({"req data", when}), v_data, req.data);
        end
    endtask

    task automatic run_vector();
        int          n;
        int          delay;
        int          limit;
        logic        saw_ld;
        logic        saw_st;
        logic [3:0]  ret;

        @(negedge clk);
        issue = {v_op, v_base, v_operand, v_st_off};
        @(negedge clk);
        issue = '0;                          // one-cycle strobe
        #5;
        n = 0;
        saw_ld = 1'b0;
        saw_st = 1'b0;
        while (!req_val && !mem_done) begin
            saw_ld = saw_ld | ld_misaligned; // flags last one cycle only
            saw_st = saw_st | st_misaligned;
            n++;
            if (n > 10) report_timeout("a request or mem_done");
            @(negedge clk);
            #5;
        end
        // two decode stages, then one FSM cycle
        check_value(vec_label("cycles to request or done"), 32'd2, 32'(n));
        check_value(vec_label("ld_misaligned"), 32'(v_ldmis), 32'(saw_ld));
        check_value(vec_label("st_misaligned"), 32'(v_stmis), 32'(saw_st));
        if (v_ldmis || v_stmis) begin
            check_value(vec_label("req_val"), 32'd0, 32'(req_val));
            check_value(vec_label("mem_err"), 32'd0, 32'(mem_err));
            return;
        end

        expect_request("");

        // cache takes the header after a random delay
        delay = $random(seed) & 32'h7;
        repeat (delay + 1) @(negedge clk);
        expect_request(" held");
        header_ack = 1'b1;
        @(negedge clk);
        header_ack = 1'b0;
        check_value(vec_label("req_val after header_ack"), 32'd0, 32'(req_val));

        if (!v_hold) begin
            ret = v_op[3] ? `MEM_ST_ACK : `MEM_LOAD_RET;
            resp = {v_d0, v_d1, ret};
            resp_val = 1'b1;
            #5;
            n = 0;
            while (!req_ack) begin
                n++;
                if (n > 10) report_timeout("req_ack");
                @(negedge clk);
                #5;
            end
            @(negedge clk);
            check_value(vec_label("req_ack pulse"), 32'd0, 32'(req_ack));
            resp_val = 1'b0;
            resp = '0;
        end

        #5;
        n = 0;
        limit = v_hold ? 100 : 10;           // timer needs 64 busy cycles
        while (!mem_done) begin
            n++;
            if (n > limit) report_timeout("mem_done");
            @(negedge clk);
            #5;
        end
        check_value(vec_label("mem_err"), 32'(v_hold), 32'(mem_err));
        check_value(vec_label("req_val after done"), 32'd0, 32'(req_val));
        if (!v_op[3] && !v_hold) begin
            check_value(vec_label("load_data"), v_load, load_data);
        end
        @(negedge clk);
        #5;
        check_value(vec_label("mem_done pulse"), 32'd0, 32'(mem_done));
        check_value(vec_label("mem_err held"), 32'(v_hold), 32'(mem_err));
    endtask

    initial begin
        int n;
        seed = 32'h145e;
        nrst = 1'b0;
        issue = '0;
        header_ack = 1'b0;
        resp = '0;
        resp_val = 1'b0;
        vec_idx = 0;
        fd = $fopen("testbench/mem_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open the vector file");
            $display("Verification failed");
            $fatal(1, "no vector file");
        end

        repeat (4) @(negedge clk);
        nrst = 1'b1;
        #5;
        check_value("reset req_val", 32'd0, 32'(req_val));
        check_value("reset mem_done", 32'd0, 32'(mem_done));
        check_value("reset mem_err", 32'd0, 32'(mem_err));
        check_value("reset ld_misaligned", 32'd0, 32'(ld_misaligned));
        check_value("reset st_misaligned", 32'd0, 32'(st_misaligned));

        n = 14;
        while (n == 14) begin
            n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v_op, v_base, v_operand, v_st_off, v_d0, v_d1,
                        v_type, v_size, v_addr, v_data, v_load,
                        v_ldmis, v_stmis, v_hold);
            if (n == 14) begin
                vec_idx++;
                run_vector();
            end
        end
        $fclose(fd);

        if (vec_idx == 0) begin
            $display("the vector file held no complete line");
            $display("Verification failed");
            $fatal(1, "no vectors");
        end else begin
            $display("Verification passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* testbench/mem_vectors.txt */
f 00001000 11223344 00000004 0000000000000000 0000000000000000 1 3 00001004 44332211 00000000 0 0 0
b 00002000 0000a1b2 00000006 0000000000000000 0000000000000000 1 2 00002006 b2a10000 00000000 0 0 0
b 00002000 0000c3d4 00000000 0000000000000000 0000000000000000 1 2 00002000 d4c30000 00000000 0 0 0
d 00003000 000000c5 00000003 0000000000000000 0000000000000000 1 1 00003003 c5000000 00000000 0 0 0
d 00003000 deadbe7f 00000001 0000000000000000 0000000000000000 1 1 00003001 7fbeadde 00000000 0 0 0
7 00004000 00000000 00000000 8192a3b4c5d6e7f8 0102f30405867708 0 3 00004000 00000000 b4a39281 0 0 0
7 00004000 00000008 00000000 8192a3b4c5d6e7f8 0102f30405867708 0 3 00004008 00000000 04f30201 0 0 0
3 00004000 00000006 00000000 8192a3b4c5d6e7f8 0102f30405867708 0 3 00004006 00000000 fffff8e7 0 0 0
2 00004000 0000000c 00000000 8192a3b4c5d6e7f8 0102f30405867708 0 3 0000400c 00000000 00008605 0 0 0
5 00004000 0000000d 00000000 8192a3b4c5d6e7f8 0102f30405867708 0 3 0000400d 00000000 ffffff86 0 0 0
4 00004000 00000001 00000000 8192a3b4c5d6e7f8 0102f30405867708 0 3 00004001 00000000 00000092 0 0 0
5 00004000 0000000a 00000000 8192a3b4c5d6e7f8 0102f30405867708 0 3 0000400a 00000000 fffffff3 0 0 0
2 00004000 00000002 00000000 8192a3b4c5d6e7f8 0102f30405867708 0 3 00004002 00000000 0000b4a3 0 0 0
7 00004000 00000002 00000000 8192a3b4c5d6e7f8 0102f30405867708 0 0 00000000 00000000 00000000 1 0 0
3 00004000 00000005 00000000 8192a3b4c5d6e7f8 0102f30405867708 0 0 00000000 00000000 00000000 1 0 0
b 00005000 00001234 00000003 0000000000000000 0000000000000000 0 0 00000000 00000000 00000000 0 1 0
f 00005000 12345678 00000001 0000000000000000 0000000000000000 0 0 00000000 00000000 00000000 0 1 0
f 00006000 55667788 00000000 0000000000000000 0000000000000000 1 3 00006000 88776655 00000000 0 0 1
7 00004000 00000004 00000000 8192a3b4c5d6e7f8 0102f30405867708 0 3 00004004 00000000 f8e7d6c5 0 0 0

/* files.f */
+incdir+source
source/mem_op_pkg.sv
source/l15_pkg.sv
source/mem_decode.sv
source/l15_req_fsm.sv
source/resp_timer.sv
source/l15_data_align.sv
source/mem_wrap.sv
testbench/mem_wrap_tb.sv

/* Makefile */
# Verilator build and run for the memory stage testbench

VERILATOR  ?= verilator
TOP        ?= mem_wrap_tb
RTL_TOP    ?= mem_wrap
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

# exit status of the simulation is the pass or fail result
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(RTL_TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
